/* bench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam logic [31:0] lcg_seed = 32'h90d0;

logic [31:0] lcg_state;
// Architectural registers updated strictly in program order
logic [31:0] model_regs [32];

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [31:0] next_rand();
    lcg_state = lcg_next(lcg_state);
    return lcg_state;
endfunction

function automatic logic [31:0] encode_r(input logic [5:0] fn, input logic [4:0] rs, rt, rd,
                                         input logic [4:0] sh);
    return {cpu_pkg::op_special, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                         input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// One instruction against model_regs with no forwarding or pipeline
function automatic void model_step(input logic [31:0] instr, output logic [4:0] rd,
                                   output logic w, output logic [31:0] val);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] ze;
    logic [4:0]  sh;
    a   = model_regs[instr[25:21]];
    b   = model_regs[instr[20:16]];
    se  = {{16{instr[15]}}, instr[15:0]};
    ze  = {16'h0000, instr[15:0]};
    sh  = instr[10:6];
    rd  = instr[20:16];
    w   = 1'b1;
    val = '0;
    case (instr[31:26])
        cpu_pkg::op_special: begin
            rd = instr[15:11];
            case (instr[5:0])
                cpu_pkg::fn_sll:  val = b << sh;
                cpu_pkg::fn_srl:  val = b >> sh;
                cpu_pkg::fn_sra:  val = $signed(b) >>> sh;
                cpu_pkg::fn_sllv: val = b << a[4:0];
                cpu_pkg::fn_srlv: val = b >> a[4:0];
                cpu_pkg::fn_srav: val = $signed(b) >>> a[4:0];
                cpu_pkg::fn_addu: val = a + b;
                cpu_pkg::fn_subu: val = a - b;
                cpu_pkg::fn_and:  val = a & b;
                cpu_pkg::fn_or:   val = a | b;
                cpu_pkg::fn_xor:  val = a ^ b;
                cpu_pkg::fn_nor:  val = ~(a | b);
                cpu_pkg::fn_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                cpu_pkg::fn_sltu: val = (a < b) ? 32'd1 : 32'd0;
                default:          w   = 1'b0;
            endcase
        end
        cpu_pkg::op_addiu: val = a + se;
        cpu_pkg::op_slti:  val = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
        cpu_pkg::op_sltiu: val = (a < se) ? 32'd1 : 32'd0;
        cpu_pkg::op_andi:  val = a & ze;
        cpu_pkg::op_ori:   val = a | ze;
        cpu_pkg::op_xori:  val = a ^ ze;
        cpu_pkg::op_lui:   val = {instr[15:0], 16'h0000};
        default:           w   = 1'b0;
    endcase
    // $0 hardwired
    if (rd == 5'd0) begin
        w = 1'b0;
    end
endfunction

`endif

/* bench/pipeline_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeline_tb;

    localparam int clk_period      = 100;
    localparam int prog_len        = 200;
    localparam int watchdog_cycles = prog_len * 5 + 50;
    // Dependent chain fetched with zero wait states
    localparam int chain_lo        = 7;
    localparam int chain_hi        = 16;

    localparam logic [5:0] fn_list [14] = '{
        cpu_pkg::fn_addu, cpu_pkg::fn_subu, cpu_pkg::fn_and, cpu_pkg::fn_or,
        cpu_pkg::fn_xor, cpu_pkg::fn_nor, cpu_pkg::fn_slt, cpu_pkg::fn_sltu,
        cpu_pkg::fn_sll, cpu_pkg::fn_srl, cpu_pkg::fn_sra, cpu_pkg::fn_sllv,
        cpu_pkg::fn_srlv, cpu_pkg::fn_srav};
    localparam logic [5:0] op_list [7] = '{
        cpu_pkg::op_addiu, cpu_pkg::op_slti, cpu_pkg::op_sltiu, cpu_pkg::op_andi,
        cpu_pkg::op_ori, cpu_pkg::op_xori, cpu_pkg::op_lui};

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        ibus_cyc;
    logic        ibus_stb;
    logic        ibus_we;
    logic [3:0]  ibus_sel;
    logic [31:0] ibus_adr;
    logic [31:0] ibus_dat = '0;
    logic        ibus_ack = 1'b0;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd_addr;
    logic        retire_reg_w;
    logic [31:0] retire_data;

    logic [31:0] prog [prog_len];
    logic [31:0] exp_adr;
    int          wait_left;
    int          retired;
    // Expected values for the retire in the current cycle
    logic [31:0] exp_pc;
    logic [31:0] exp_data;
    logic [4:0]  exp_rd;
    logic        exp_w;
    logic        chk_alu;
    logic        chk_shift;
    logic        chk_chain;
    logic        chk_none;
    string       exp_name;

    `include "tb_model.svh"

    pipeline UUT (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] adr);
        // All zero past the program (sll $0)
        return (adr[31:2] < prog_len) ? prog[adr[31:2]] : '0;
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] r1;
        logic [31:0] r2;
        int          kind;
        r1   = next_rand();
        r2   = next_rand();
        kind = int'(r1[15:11]) % 21;
        // Registers $0..$7 only so dependencies are dense
        if (kind < 14) begin
            return encode_r(fn_list[kind], {2'b00, r1[18:16]}, {2'b00, r1[21:19]},
                            {2'b00, r1[24:22]}, r1[29:25]);
        end
        return encode_i(op_list[kind-14], {2'b00, r1[18:16]}, {2'b00, r1[21:19]}, r2[31:16]);
    endfunction

    task automatic build_program();
        logic [31:0] r;
        for (int i = 1; i < 8; i++) begin
            r         = next_rand();
            prog[i-1] = encode_i(cpu_pkg::op_addiu, 5'd0, 5'(i), r[31:16]);
        end
        prog[7]  = encode_r(cpu_pkg::fn_addu, 5'd1, 5'd2, 5'd3, 5'd0);
        prog[8]  = encode_r(cpu_pkg::fn_subu, 5'd3, 5'd1, 5'd4, 5'd0);
        prog[9]  = encode_r(cpu_pkg::fn_xor, 5'd3, 5'd4, 5'd5, 5'd0);
        // Forwarded shift amount
        prog[10] = encode_r(cpu_pkg::fn_sllv, 5'd5, 5'd4, 5'd6, 5'd0);
        prog[11] = encode_i(cpu_pkg::op_ori, 5'd6, 5'd7, 16'h00ff);
        prog[12] = encode_r(cpu_pkg::fn_sra, 5'd0, 5'd7, 5'd7, 5'd4);
        prog[13] = encode_r(cpu_pkg::fn_slt, 5'd7, 5'd6, 5'd1, 5'd0);
        prog[14] = encode_i(cpu_pkg::op_addiu, 5'd1, 5'd1, 16'hffff);
        prog[15] = encode_r(cpu_pkg::fn_srav, 5'd1, 5'd7, 5'd2, 5'd0);
        prog[16] = encode_r(cpu_pkg::fn_nor, 5'd2, 5'd1, 5'd3, 5'd0);
        for (int i = chain_hi + 1; i < prog_len; i++) begin
            prog[i] = random_instr();
        end
        // Unknown opcode, a write to $0, a read of $0, lw and movz
        prog[60]  = 32'hfc00_0000;
        prog[61]  = encode_i(cpu_pkg::op_addiu, 5'd1, 5'd0, 16'h1234);
        prog[62]  = encode_r(cpu_pkg::fn_addu, 5'd0, 5'd0, 5'd5, 5'd0);
        prog[95]  = 32'h8c22_0004;
        prog[130] = encode_r(6'h0a, 5'd1, 5'd2, 5'd3, 5'd0);
    endtask

    function automatic int pick_wait(input logic [31:0] adr);
        logic [31:0] r;
        if ((adr[31:2] >= chain_lo && adr[31:2] <= chain_hi) ||
            (adr[31:2] >= 100 && adr[31:2] < 116)) begin
            return 0;
        end
        r = next_rand();
        return int'(r[25:24]);
    endfunction

    ////////////////////
    // Wishbone slave
    ////////////////////

    always @(posedge clk) begin
        #10;
        // Ack still high means a transfer just completed
        if (ibus_ack) begin
            exp_adr   = exp_adr + 32'd4;
            wait_left = pick_wait(exp_adr);
        end
        if (ibus_stb && wait_left == 0) begin
            ibus_ack = 1'b1;
            ibus_dat = fetch_word(ibus_adr);
        end else begin
            ibus_ack = 1'b0;
            if (ibus_stb) begin
                wait_left--;
            end
        end
    end

    // Expectation for the retire now on the port before it goes into the model
    always @(negedge clk) begin : track_retire
        logic [31:0] instr;
        if (!rst && retire_valid) begin
            instr  = fetch_word(32'(retired) << 2);
            exp_pc = 32'(retired) << 2;
            model_step(instr, exp_rd, exp_w, exp_data);
            chk_none  = !exp_w;
            chk_chain = exp_w && retired >= chain_lo && retired <= chain_hi;
            chk_shift = exp_w && !chk_chain && instr[31:26] == cpu_pkg::op_special &&
                        instr[5:3] == 3'b000;
            chk_alu   = exp_w && !chk_chain && !chk_shift;
            exp_name  = chk_chain ? "hazard_forwarding" :
                        chk_shift ? "shift_results" : "alu_results";
            if (exp_w) begin
                model_regs[exp_rd] = exp_data;
            end
            retired++;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    reset_idle: assert property (@(posedge clk) rst |=> !ibus_cyc && !ibus_stb)
        else report_error("fetch_protocol: cyc or stb high during reset");
    fetch_start: assert property (@(posedge clk) $fell(rst) |=> ibus_cyc && ibus_stb)
        else report_error("fetch_protocol: fetch did not start after reset");
    fetch_fixed: assert property (@(posedge clk) disable iff (rst)
        ibus_stb == ibus_cyc && !ibus_we && ibus_sel == 4'hf)
        else report_error("fetch_protocol: cyc, stb, we or sel out of spec");
    fetch_addr: assert property (@(posedge clk) disable iff (rst)
        ibus_stb |-> ibus_adr == exp_adr)
        else report_mismatch("fetch_protocol", $sampled(exp_adr), $sampled(ibus_adr));
    fetch_hold: assert property (@(posedge clk) disable iff (rst)
        ibus_stb && !ibus_ack |=> $stable(ibus_adr))
        else report_error("fetch_protocol: address moved during a wait state");

    retire_latency: assert property (@(posedge clk) disable iff (rst)
        ibus_stb && ibus_ack |-> ##3 retire_valid)
        else report_error("retire_order: no retire 3 cycles after an ack");
    retire_source: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> $past(ibus_stb && ibus_ack, 3))
        else report_error("retire_order: retire without an ack 3 cycles earlier");
    retire_pc_order: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_pc == exp_pc)
        else report_mismatch("retire_order", $sampled(exp_pc), $sampled(retire_pc));

    write_target: assert property (@(posedge clk) disable iff (rst)
        retire_valid && exp_w |-> retire_reg_w && retire_rd_addr == exp_rd)
        else report_mismatch(exp_name, {26'd0, 1'b1, exp_rd},
                             {26'd0, $sampled(retire_reg_w), $sampled(retire_rd_addr)});
    alu_results: assert property (@(posedge clk) disable iff (rst)
        retire_valid && chk_alu |-> retire_data == exp_data)
        else report_mismatch("alu_results", exp_data, $sampled(retire_data));
    shift_results: assert property (@(posedge clk) disable iff (rst)
        retire_valid && chk_shift |-> retire_data == exp_data)
        else report_mismatch("shift_results", exp_data, $sampled(retire_data));
    hazard_forwarding: assert property (@(posedge clk) disable iff (rst)
        retire_valid && chk_chain |-> retire_data == exp_data)
        else report_mismatch("hazard_forwarding", exp_data, $sampled(retire_data));
    no_write_cases: assert property (@(posedge clk) disable iff (rst)
        retire_valid && chk_none |-> !retire_reg_w)
        else report_mismatch("no_write_cases", 32'd0, {31'd0, $sampled(retire_reg_w)});

    initial begin
        lcg_state = lcg_seed;
        exp_adr   = cpu_pkg::pc_reset;
        retired   = 0;
        exp_w     = 1'b0;
        chk_alu   = 1'b0;
        chk_shift = 1'b0;
        chk_chain = 1'b0;
        chk_none  = 1'b0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        build_program();
        wait_left = pick_wait(cpu_pkg::pc_reset);
        repeat (5) @(posedge clk);
        #10 rst = 1'b0;
        wait (retired == prog_len);
        // Let the last retire be checked
        @(posedge clk);
        #10;
        $display("sim passed");
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Retirement stalled, %0d of %0d instructions retired", retired, prog_len);
        $display("sim failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* pipeline.f */
+incdir+bench
source/cpu_pkg.sv
source/fetch_unit.sv
source/decoder.sv
source/register_file.sv
source/execute_unit.sv
source/pipeline.sv
bench/pipeline_tb.sv

/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    ////////////////////
    // Datapath sizes
    ////////////////////

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;
    localparam int shamt_w    = 5;

    // First fetch address
    localparam logic [data_w-1:0] pc_reset = '0;

    ////////////////////
    // Primary opcodes
    ////////////////////

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;

    // SPECIAL function codes with the shifts first
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // One code for both ALU and shifter
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_lui,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

endpackage

`default_nettype wire

/* source/decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           id_valid,
    input  logic [cpu_pkg::data_w-1:0]     id_pc,
    input  logic [cpu_pkg::data_w-1:0]     id_instr,
    // Register file read
    output logic [cpu_pkg::reg_addr_w-1:0] rs_addr,
    output logic [cpu_pkg::reg_addr_w-1:0] rt_addr,
    input  logic [cpu_pkg::data_w-1:0]     rs_data,
    input  logic [cpu_pkg::data_w-1:0]     rt_data,
    // To execute
    output logic                           ex_valid,
    output logic [cpu_pkg::data_w-1:0]     ex_pc,
    output cpu_pkg::alu_op_t               ex_alu_op,
    output logic [cpu_pkg::data_w-1:0]     ex_op_a,
    output logic [cpu_pkg::data_w-1:0]     ex_op_b,
    output logic [cpu_pkg::reg_addr_w-1:0] ex_rs_addr,
    output logic [cpu_pkg::reg_addr_w-1:0] ex_rt_addr,
    output logic [cpu_pkg::shamt_w-1:0]    ex_shamt,
    output logic                           ex_shamt_sel,
    output logic [cpu_pkg::reg_addr_w-1:0] ex_rd_addr,
    output logic                           ex_reg_w
);

    logic [5:0]                     opcode;
    logic [5:0]                     funct;
    logic [cpu_pkg::reg_addr_w-1:0] rs_field;
    logic [cpu_pkg::reg_addr_w-1:0] rt_field;
    logic [cpu_pkg::reg_addr_w-1:0] rd_field;
    logic [15:0]                    imm;
    logic                           r_type;
    logic                           known;
    logic                           sign_ext;
    logic                           is_shift;
    logic                           var_shift;
    cpu_pkg::alu_op_t               alu_op;
    logic [cpu_pkg::data_w-1:0]     imm_ext;
    logic [cpu_pkg::reg_addr_w-1:0] dest;

    // Instruction fields
    assign opcode   = id_instr[31:26];
    assign rs_field = id_instr[21 +: cpu_pkg::reg_addr_w];
    assign rt_field = id_instr[16 +: cpu_pkg::reg_addr_w];
    assign rd_field = id_instr[11 +: cpu_pkg::reg_addr_w];
    assign funct    = id_instr[5:0];
    assign imm      = id_instr[15:0];
    assign r_type   = opcode == cpu_pkg::op_special;

    ////////////////////
    // Opcode decode
    ////////////////////

    always_comb begin
        alu_op = cpu_pkg::alu_add;
        known  = 1'b1;
        if (r_type) begin
            case (funct)
                cpu_pkg::fn_sll, cpu_pkg::fn_sllv: alu_op = cpu_pkg::alu_sll;
                cpu_pkg::fn_srl, cpu_pkg::fn_srlv: alu_op = cpu_pkg::alu_srl;
                cpu_pkg::fn_sra, cpu_pkg::fn_srav: alu_op = cpu_pkg::alu_sra;
                cpu_pkg::fn_addu: alu_op = cpu_pkg::alu_add;
                cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
                cpu_pkg::fn_and:  alu_op = cpu_pkg::alu_and;
                cpu_pkg::fn_or:   alu_op = cpu_pkg::alu_or;
                cpu_pkg::fn_xor:  alu_op = cpu_pkg::alu_xor;
                cpu_pkg::fn_nor:  alu_op = cpu_pkg::alu_nor;
                cpu_pkg::fn_slt:  alu_op = cpu_pkg::alu_slt;
                cpu_pkg::fn_sltu: alu_op = cpu_pkg::alu_sltu;
                default:          known  = 1'b0;
            endcase
        end else begin
            case (opcode)
                cpu_pkg::op_addiu: alu_op = cpu_pkg::alu_add;
                cpu_pkg::op_slti:  alu_op = cpu_pkg::alu_slt;
                cpu_pkg::op_sltiu: alu_op = cpu_pkg::alu_sltu;
                cpu_pkg::op_andi:  alu_op = cpu_pkg::alu_and;
                cpu_pkg::op_ori:   alu_op = cpu_pkg::alu_or;
                cpu_pkg::op_xori:  alu_op = cpu_pkg::alu_xor;
                cpu_pkg::op_lui:   alu_op = cpu_pkg::alu_lui;
                default:           known  = 1'b0;
            endcase
        end
    end

    // Shift functs sit in 0..7, bit 2 picks amount from rs
    assign is_shift  = r_type && known && funct[5:3] == 3'b000;
    assign var_shift = is_shift && funct[2];

    // Arithmetic and compare immediates sign extend, logic ones zero extend
    assign sign_ext = opcode == cpu_pkg::op_addiu || opcode == cpu_pkg::op_slti ||
                      opcode == cpu_pkg::op_sltiu;
    assign imm_ext  = {{(cpu_pkg::data_w-16){sign_ext & imm[15]}}, imm};

    // rd for R-type, rt for immediates
    assign dest = r_type ? rd_field : rt_field;

    // $0 selectors keep forwarding off unused operands
    assign rs_addr = (is_shift && !var_shift) ? '0 : rs_field;
    assign rt_addr = r_type ? rt_field : '0;

    ////////////////////
    // ID/EX register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_reg_w <= 1'b0;
        end else begin
            ex_valid <= id_valid;
            // No write for unknown encodings or $0
            ex_reg_w <= id_valid && known && dest != '0;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc        <= id_pc;
        ex_alu_op    <= alu_op;
        ex_op_a      <= rs_data;
        ex_op_b      <= r_type ? rt_data : imm_ext;
        ex_rs_addr   <= rs_addr;
        ex_rt_addr   <= rt_addr;
        ex_shamt     <= id_instr[6 +: cpu_pkg::shamt_w];
        ex_shamt_sel <= var_shift;
        ex_rd_addr   <= dest;
    end

endmodule

`default_nettype wire

/* source/execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ex_valid,
    input  logic [cpu_pkg::data_w-1:0]     ex_pc,
    input  cpu_pkg::alu_op_t               ex_alu_op,
    input  logic [cpu_pkg::data_w-1:0]     ex_op_a,
    input  logic [cpu_pkg::data_w-1:0]     ex_op_b,
    input  logic [cpu_pkg::reg_addr_w-1:0] ex_rs_addr,
    input  logic [cpu_pkg::reg_addr_w-1:0] ex_rt_addr,
    input  logic [cpu_pkg::shamt_w-1:0]    ex_shamt,
    input  logic                           ex_shamt_sel,
    input  logic [cpu_pkg::reg_addr_w-1:0] ex_rd_addr,
    input  logic                           ex_reg_w,
    // Write-back register
    output logic                           wb_valid,
    output logic [cpu_pkg::data_w-1:0]     wb_pc,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_rd_addr,
    output logic                           wb_reg_w,
    output logic [cpu_pkg::data_w-1:0]     wb_data
);

    logic [cpu_pkg::data_w-1:0] op_a;
    logic [cpu_pkg::data_w-1:0] op_b;
    logic [cpu_pkg::shamt_w-1:0] shamt;
    logic                       lt_s;
    logic                       lt_u;
    logic                       use_shift;
    logic [cpu_pkg::data_w-1:0] alu_out;
    logic [cpu_pkg::data_w-1:0] shift_out;
    logic [cpu_pkg::data_w-1:0] result;

    ////////////////////
    // Forwarding
    ////////////////////

    // Only source is our own WB register as older values come via the RF bypass
    assign op_a = (wb_reg_w && wb_valid && wb_rd_addr == ex_rs_addr) ? wb_data : ex_op_a;
    assign op_b = (wb_reg_w && wb_valid && wb_rd_addr == ex_rt_addr) ? wb_data : ex_op_b;

    // Shift amount from the instruction or from rs
    assign shamt = ex_shamt_sel ? op_a[cpu_pkg::shamt_w-1:0] : ex_shamt;

    ////////////////////
    // ALU
    ////////////////////

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    always_comb begin
        case (ex_alu_op)
            cpu_pkg::alu_sub:  alu_out = op_a - op_b;
            cpu_pkg::alu_and:  alu_out = op_a & op_b;
            cpu_pkg::alu_or:   alu_out = op_a | op_b;
            cpu_pkg::alu_xor:  alu_out = op_a ^ op_b;
            cpu_pkg::alu_nor:  alu_out = ~(op_a | op_b);
            cpu_pkg::alu_slt:  alu_out = {{(cpu_pkg::data_w-1){1'b0}}, lt_s};
            cpu_pkg::alu_sltu: alu_out = {{(cpu_pkg::data_w-1){1'b0}}, lt_u};
            // Immediate into the upper half
            cpu_pkg::alu_lui:  alu_out = {op_b[cpu_pkg::data_w/2-1:0],
                                          {(cpu_pkg::data_w/2){1'b0}}};
            default:           alu_out = op_a + op_b;
        endcase
    end

    // Barrel shifter works on rt
    always_comb begin
        case (ex_alu_op)
            cpu_pkg::alu_srl: shift_out = op_b >> shamt;
            cpu_pkg::alu_sra: shift_out = $signed(op_b) >>> shamt;
            default:          shift_out = op_b << shamt;
        endcase
    end

    assign use_shift = ex_alu_op inside {cpu_pkg::alu_sll, cpu_pkg::alu_srl, cpu_pkg::alu_sra};
    assign result    = use_shift ? shift_out : alu_out;

    ////////////////////
    // EX/WB register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_reg_w <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            wb_reg_w <= ex_reg_w;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc      <= ex_pc;
        wb_rd_addr <= ex_rd_addr;
        wb_data    <= result;
    end

    // A bubble must never reach the RF write or the forwarding path
    bubble_no_write: assert property (@(posedge clk) disable iff (rst)
        !wb_valid |-> !wb_reg_w);

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  logic                       clk,
    input  logic                       rst,
    // Wishbone classic instruction port
    input  logic                       ibus_ack,
    input  logic [cpu_pkg::data_w-1:0] ibus_dat,
    output logic                       ibus_cyc,
    output logic                       ibus_stb,
    output logic                       ibus_we,
    output logic [3:0]                 ibus_sel,
    output logic [cpu_pkg::data_w-1:0] ibus_adr,
    // To decode
    output logic                       id_valid,
    output logic [cpu_pkg::data_w-1:0] id_pc,
    output logic [cpu_pkg::data_w-1:0] id_instr
);

    logic [cpu_pkg::data_w-1:0] pc;
    logic                       fetch_on;
    logic                       take;

    // Transfer done on stb and ack together
    assign take = ibus_stb && ibus_ack;

    ////////////////////
    // PC register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= cpu_pkg::pc_reset;
            fetch_on <= 1'b0;
        end else begin
            // Request held from the first cycle out of reset
            fetch_on <= 1'b1;
            if (take) begin
                pc <= pc + 'd4;
            end
        end
    end

    // Read only over the whole word
    assign ibus_cyc = fetch_on;
    assign ibus_stb = fetch_on;
    assign ibus_we  = 1'b0;
    assign ibus_sel = 4'b1111;
    assign ibus_adr = pc;

    ////////////////////
    // IF/ID register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
        end else begin
            // Bubble on wait state
            id_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            id_pc    <= pc;
            id_instr <= ibus_dat;
        end
    end

    // Slave may only ack an open request
    ack_inside_cyc: assert property (@(posedge clk) disable iff (rst)
        ibus_ack |-> ibus_cyc && ibus_stb);

    // Request may not move or drop while the slave waits
    adr_held_in_wait: assert property (@(posedge clk) disable iff (rst)
        ibus_stb && !ibus_ack |=> ibus_stb && $stable(ibus_adr));

endmodule

`default_nettype wire

/* source/pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeline (
    input  logic                           clk,
    input  logic                           rst,
    // Wishbone classic instruction master
    output logic                           ibus_cyc,
    output logic                           ibus_stb,
    output logic                           ibus_we,
    output logic [3:0]                     ibus_sel,
    output logic [cpu_pkg::data_w-1:0]     ibus_adr,
    input  logic [cpu_pkg::data_w-1:0]     ibus_dat,
    input  logic                           ibus_ack,
    // One entry per finished instruction
    output logic                           retire_valid,
    output logic [cpu_pkg::data_w-1:0]     retire_pc,
    output logic [cpu_pkg::reg_addr_w-1:0] retire_rd_addr,
    output logic                           retire_reg_w,
    output logic [cpu_pkg::data_w-1:0]     retire_data
);

    // IF to ID
    logic                           id_valid;
    logic [cpu_pkg::data_w-1:0]     id_pc;
    logic [cpu_pkg::data_w-1:0]     id_instr;

    // ID to RF
    logic [cpu_pkg::reg_addr_w-1:0] rs_addr;
    logic [cpu_pkg::reg_addr_w-1:0] rt_addr;
    logic [cpu_pkg::data_w-1:0]     rs_data;
    logic [cpu_pkg::data_w-1:0]     rt_data;

    // ID to EX
    logic                           ex_valid;
    logic [cpu_pkg::data_w-1:0]     ex_pc;
    cpu_pkg::alu_op_t               ex_alu_op;
    logic [cpu_pkg::data_w-1:0]     ex_op_a;
    logic [cpu_pkg::data_w-1:0]     ex_op_b;
    logic [cpu_pkg::reg_addr_w-1:0] ex_rs_addr;
    logic [cpu_pkg::reg_addr_w-1:0] ex_rt_addr;
    logic [cpu_pkg::shamt_w-1:0]    ex_shamt;
    logic                           ex_shamt_sel;
    logic [cpu_pkg::reg_addr_w-1:0] ex_rd_addr;
    logic                           ex_reg_w;

    // EX to WB, RF and retire
    logic                           wb_valid;
    logic [cpu_pkg::data_w-1:0]     wb_pc;
    logic [cpu_pkg::reg_addr_w-1:0] wb_rd_addr;
    logic                           wb_reg_w;
    logic [cpu_pkg::data_w-1:0]     wb_data;

    // Stage ports share names with the nets above
    fetch_unit    fetch   (.*);
    decoder       decode  (.*);
    register_file gpr     (.*);
    execute_unit  execute (.*);

    // Retire is the write-back stage as is
    assign retire_valid   = wb_valid;
    assign retire_pc      = wb_pc;
    assign retire_rd_addr = wb_rd_addr;
    assign retire_reg_w   = wb_reg_w;
    assign retire_data    = wb_data;

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [cpu_pkg::reg_addr_w-1:0] rt_addr,
    output logic [cpu_pkg::data_w-1:0]     rs_data,
    output logic [cpu_pkg::data_w-1:0]     rt_data,
    // Write-back port
    input  logic                           wb_valid,
    input  logic                           wb_reg_w,
    input  logic [cpu_pkg::reg_addr_w-1:0] wb_rd_addr,
    input  logic [cpu_pkg::data_w-1:0]     wb_data
);

    logic [cpu_pkg::data_w-1:0] regs [cpu_pkg::reg_count];
    logic                       write;

    assign write = wb_valid && wb_reg_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpu_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write) begin
            regs[wb_rd_addr] <= wb_data;
        end
    end

    // $0 reads zero, same-cycle write passes straight through
    function automatic logic [cpu_pkg::data_w-1:0] read_port(
        input logic [cpu_pkg::reg_addr_w-1:0] addr
    );
        return (addr == '0) ? '0 :
               (write && addr == wb_rd_addr) ? wb_data : regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    // Decode must have dropped writes to $0
    no_zero_write: assert property (@(posedge clk) disable iff (rst)
        write |-> wb_rd_addr != '0);

endmodule

`default_nettype wire
